// ==== wr_conv_pkg.sv ====
package wr_conv_pkg;

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // AXI4 length field and the AXI3 limit of 16 beats per burst.
  localparam int LEN_W     = 8;
  localparam int SUB_BEATS = 16;
  localparam int SUB_LEN_W = $clog2(SUB_BEATS);
  localparam int REP_W     = LEN_W - SUB_LEN_W;
  localparam int SUB_BYTES = SUB_BEATS * STRB_W;  // Address step between sub-bursts.

  localparam int CMD_DEPTH = 4;
  localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

  typedef logic [1:0] resp_t;

  // Higher code means a worse outcome, so merging keeps the maximum.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_EXOKAY = 2'b01;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    logic             split;    // Burst was broken into more than one sub-burst.
    logic [REP_W-1:0] repeats;  // Number of sub-bursts minus one.
  } b_cmd_t;

  typedef struct packed {
    logic [LEN_W-1:0] len;      // Original burst length minus one.
  } w_cmd_t;

endpackage

// ==== cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo import wr_conv_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     ACLK,
  input  logic     ARESET,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t             mem [CMD_DEPTH];
  logic [CMD_PTR_W-1:0] wr_ptr;
  logic [CMD_PTR_W-1:0] rd_ptr;
  logic [CMD_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign in_ready  = (count != CMD_CNT_W'(CMD_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // A simultaneous push and pop leaves the occupancy unchanged.
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== aw_splitter.sv ====
`timescale 1ns/1ps

module aw_splitter import wr_conv_pkg::*; (
  input  logic                 ACLK,
  input  logic                 ARESET,

  input  logic [ID_W-1:0]      s_awid,
  input  logic [ADDR_W-1:0]    s_awaddr,
  input  logic [LEN_W-1:0]     s_awlen,
  input  logic                 s_awvalid,
  output logic                 s_awready,

  output logic [ID_W-1:0]      m_awid,
  output logic [ADDR_W-1:0]    m_awaddr,
  output logic [SUB_LEN_W-1:0] m_awlen,
  output logic                 m_awvalid,
  input  logic                 m_awready,

  output w_cmd_t               w_cmd_data,
  output logic                 w_cmd_valid,
  input  logic                 w_cmd_ready,

  output b_cmd_t               b_cmd_data,
  output logic                 b_cmd_valid,
  input  logic                 b_cmd_ready
);

  logic              busy;
  logic [ID_W-1:0]   cur_id;
  logic [ADDR_W-1:0] cur_addr;
  logic [LEN_W-1:0]  remain;     // Beats still to issue, minus one.
  logic              s_aw_hs;
  logic              m_aw_hs;
  logic              last_sub;

  // New bursts are taken only when both command queues can record them.
  assign s_awready = ~busy & w_cmd_ready & b_cmd_ready;
  assign s_aw_hs   = s_awvalid & s_awready;
  assign m_aw_hs   = m_awvalid & m_awready;

  assign last_sub = (remain < LEN_W'(SUB_BEATS));

  assign m_awvalid = busy;
  assign m_awid    = cur_id;
  assign m_awaddr  = cur_addr;
  assign m_awlen   = last_sub ? remain[SUB_LEN_W-1:0] : '1;

  // Both commands are pushed in the accepting cycle.
  assign w_cmd_valid = s_aw_hs;
  assign b_cmd_valid = s_aw_hs;

  always_comb begin
    w_cmd_data.len = s_awlen;
  end

  always_comb begin
    b_cmd_data.split   = (s_awlen >= LEN_W'(SUB_BEATS));
    b_cmd_data.repeats = s_awlen[LEN_W-1:SUB_LEN_W];  // Length divided by 16.
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      busy <= 1'b0;
    end else if (s_aw_hs) begin
      busy <= 1'b1;
    end else if (m_aw_hs && last_sub) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (s_aw_hs) begin
      cur_id   <= s_awid;
      cur_addr <= s_awaddr;
      remain   <= s_awlen;
    end else if (m_aw_hs && !last_sub) begin
      cur_addr <= cur_addr + ADDR_W'(SUB_BYTES);
      remain   <= remain - LEN_W'(SUB_BEATS);
    end
  end

endmodule

// ==== w_last_gen.sv ====
`timescale 1ns/1ps

module w_last_gen import wr_conv_pkg::*; (
  input  logic              ACLK,
  input  logic              ARESET,

  input  logic [LEN_W-1:0]  cmd_len,
  input  logic              cmd_valid,
  output logic              cmd_ready,

  input  logic [DATA_W-1:0] s_wdata,
  input  logic [STRB_W-1:0] s_wstrb,
  input  logic              s_wvalid,
  output logic              s_wready,

  output logic [DATA_W-1:0] m_wdata,
  output logic [STRB_W-1:0] m_wstrb,
  output logic              m_wlast,
  output logic              m_wvalid,
  input  logic              m_wready
);

  logic [LEN_W-1:0] beat_cnt;  // Beat index within the original burst.
  logic             beat_hs;
  logic             final_beat;
  logic             sub_end;

  // Beats only move once the length of their burst is known.
  assign m_wvalid = s_wvalid & cmd_valid;
  assign s_wready = m_wready & cmd_valid;
  assign beat_hs  = m_wvalid & m_wready;

  assign m_wdata = s_wdata;
  assign m_wstrb = s_wstrb;

  assign final_beat = (beat_cnt == cmd_len);
  assign sub_end    = (beat_cnt[SUB_LEN_W-1:0] == '1);  // Every 16th beat.
  assign m_wlast    = final_beat | sub_end;

  assign cmd_ready = beat_hs & final_beat;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      beat_cnt <= '0;
    end else if (beat_hs) begin
      if (final_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== b_merger.sv ====
`timescale 1ns/1ps

module b_merger import wr_conv_pkg::*; (
  input  logic             ACLK,
  input  logic             ARESET,

  input  logic             cmd_split,
  input  logic [REP_W-1:0] cmd_repeat,
  input  logic             cmd_valid,
  output logic             cmd_ready,

  output logic [ID_W-1:0]  s_bid,
  output resp_t            s_bresp,
  output logic             s_bvalid,
  input  logic             s_bready,

  input  logic [ID_W-1:0]  m_bid,
  input  resp_t            m_bresp,
  input  logic             m_bvalid,
  output logic             m_bready
);

  logic             first_resp;   // Next response opens a new original burst.
  logic             last_resp;
  logic             stall;
  logic             pop;
  logic [REP_W-1:0] rep_cnt;
  logic [REP_W-1:0] rep_cnt_pre;
  resp_t            resp_acc;
  resp_t            resp_merged;

  assign last_resp = ~cmd_split | (~first_resp & (rep_cnt == '0));

  // Only the final response waits for the upstream master.
  assign stall    = last_resp & ~s_bready;
  assign m_bready = m_bvalid & cmd_valid & ~stall;
  assign pop      = m_bvalid & m_bready;

  assign cmd_ready = pop & last_resp;
  assign s_bvalid  = m_bvalid & cmd_valid & last_resp;
  assign s_bid     = m_bid;
  assign s_bresp   = resp_merged;

  always_comb begin
    if (!cmd_split) begin
      resp_merged = m_bresp;
    end else if (first_resp || (m_bresp > resp_acc)) begin
      resp_merged = m_bresp;  // Worst code seen so far wins.
    end else begin
      resp_merged = resp_acc;
    end
  end

  always_comb begin
    if (first_resp) begin
      rep_cnt_pre = cmd_repeat;
    end else begin
      rep_cnt_pre = rep_cnt;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      resp_acc   <= RESP_OKAY;
      rep_cnt    <= '0;
      first_resp <= 1'b1;
    end else if (pop) begin
      resp_acc   <= resp_merged;
      rep_cnt    <= rep_cnt_pre - 1'b1;
      first_resp <= last_resp;
    end
  end

endmodule

// ==== wr_conv_top.sv ====
`timescale 1ns/1ps

module wr_conv_top import wr_conv_pkg::*; (
  input  logic                 ACLK,
  input  logic                 ARESET,

  input  logic [ID_W-1:0]      s_awid,
  input  logic [ADDR_W-1:0]    s_awaddr,
  input  logic [LEN_W-1:0]     s_awlen,
  input  logic                 s_awvalid,
  output logic                 s_awready,
  input  logic [DATA_W-1:0]    s_wdata,
  input  logic [STRB_W-1:0]    s_wstrb,
  input  logic                 s_wlast,
  input  logic                 s_wvalid,
  output logic                 s_wready,
  output logic [ID_W-1:0]      s_bid,
  output resp_t                s_bresp,
  output logic                 s_bvalid,
  input  logic                 s_bready,

  output logic [ID_W-1:0]      m_awid,
  output logic [ADDR_W-1:0]    m_awaddr,
  output logic [SUB_LEN_W-1:0] m_awlen,
  output logic                 m_awvalid,
  input  logic                 m_awready,
  output logic [DATA_W-1:0]    m_wdata,
  output logic [STRB_W-1:0]    m_wstrb,
  output logic                 m_wlast,
  output logic                 m_wvalid,
  input  logic                 m_wready,
  input  logic [ID_W-1:0]      m_bid,
  input  resp_t                m_bresp,
  input  logic                 m_bvalid,
  output logic                 m_bready
);

  w_cmd_t w_cmd_in_data;
  logic   w_cmd_in_valid;
  logic   w_cmd_in_ready;
  w_cmd_t w_cmd_out_data;
  logic   w_cmd_out_valid;
  logic   w_cmd_out_ready;

  b_cmd_t b_cmd_in_data;
  logic   b_cmd_in_valid;
  logic   b_cmd_in_ready;
  b_cmd_t b_cmd_out_data;
  logic   b_cmd_out_valid;
  logic   b_cmd_out_ready;

  aw_splitter u_aw_splitter (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .s_awid      (s_awid),
    .s_awaddr    (s_awaddr),
    .s_awlen     (s_awlen),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .m_awid      (m_awid),
    .m_awaddr    (m_awaddr),
    .m_awlen     (m_awlen),
    .m_awvalid   (m_awvalid),
    .m_awready   (m_awready),
    .w_cmd_data  (w_cmd_in_data),
    .w_cmd_valid (w_cmd_in_valid),
    .w_cmd_ready (w_cmd_in_ready),
    .b_cmd_data  (b_cmd_in_data),
    .b_cmd_valid (b_cmd_in_valid),
    .b_cmd_ready (b_cmd_in_ready)
  );

  cmd_fifo #(.payload_t(w_cmd_t)) u_w_cmd (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .in_data   (w_cmd_in_data),
    .in_valid  (w_cmd_in_valid),
    .in_ready  (w_cmd_in_ready),
    .out_data  (w_cmd_out_data),
    .out_valid (w_cmd_out_valid),
    .out_ready (w_cmd_out_ready)
  );

  cmd_fifo #(.payload_t(b_cmd_t)) u_b_cmd (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .in_data   (b_cmd_in_data),
    .in_valid  (b_cmd_in_valid),
    .in_ready  (b_cmd_in_ready),
    .out_data  (b_cmd_out_data),
    .out_valid (b_cmd_out_valid),
    .out_ready (b_cmd_out_ready)
  );

  w_last_gen u_w_last_gen (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .cmd_len   (w_cmd_out_data.len),
    .cmd_valid (w_cmd_out_valid),
    .cmd_ready (w_cmd_out_ready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .m_wdata   (m_wdata),
    .m_wstrb   (m_wstrb),
    .m_wlast   (m_wlast),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready)
  );

  b_merger u_b_merger (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .cmd_split  (b_cmd_out_data.split),
    .cmd_repeat (b_cmd_out_data.repeats),
    .cmd_valid  (b_cmd_out_valid),
    .cmd_ready  (b_cmd_out_ready),
    .s_bid      (s_bid),
    .s_bresp    (s_bresp),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready),
    .m_bid      (m_bid),
    .m_bresp    (m_bresp),
    .m_bvalid   (m_bvalid),
    .m_bready   (m_bready)
  );

endmodule

// ==== wr_conv_asserts.sv ====
`timescale 1ns/1ps

module wr_conv_asserts import wr_conv_pkg::*; (
  input logic                 ACLK,
  input logic                 ARESET,
  input logic                 s_awvalid,
  input logic                 s_awready,
  input logic [ID_W-1:0]      m_awid,
  input logic [ADDR_W-1:0]    m_awaddr,
  input logic [SUB_LEN_W-1:0] m_awlen,
  input logic                 m_awvalid,
  input logic                 m_awready,
  input logic                 m_wlast,
  input logic                 m_wvalid,
  input logic                 m_wready,
  input logic [ID_W-1:0]      s_bid,
  input resp_t                s_bresp,
  input logic                 s_bvalid,
  input logic                 s_bready
);

  logic [SUB_LEN_W-1:0] w_beats;      // Beats since the last m_wlast.
  logic [CMD_CNT_W:0]   outstanding;  // Accepted bursts still without a response.
  logic                 s_aw_hs;
  logic                 s_b_hs;

  assign s_aw_hs = s_awvalid & s_awready;
  assign s_b_hs  = s_bvalid & s_bready;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      w_beats <= '0;
    end else if (m_wvalid && m_wready) begin
      w_beats <= m_wlast ? '0 : w_beats + 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      outstanding <= '0;
    end else if (s_aw_hs && !s_b_hs) begin
      outstanding <= outstanding + 1'b1;
    end else if (s_b_hs && !s_aw_hs) begin
      outstanding <= outstanding - 1'b1;
    end
  end

  // A stalled sub-burst keeps its valid and its fields until taken.
  aw_stable: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid && !m_awready |=> m_awvalid && $stable({m_awid, m_awaddr, m_awlen}))
    else $error("m_aw changed before its handshake");

  b_stable: assert property (@(posedge ACLK) disable iff (ARESET)
    s_bvalid && !s_bready |=> s_bvalid && $stable({s_bid, s_bresp}))
    else $error("s_b changed before its handshake");

  w_len_max: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && m_wready && (w_beats == SUB_LEN_W'(SUB_BEATS - 1)) |-> m_wlast)
    else $error("m_w burst longer than the AXI3 limit of 16 beats");

  // Every merged response belongs to a recorded burst.
  b_has_cmd: assert property (@(posedge ACLK) disable iff (ARESET)
    s_b_hs |-> (outstanding != '0))
    else $error("s_b transfer with no burst awaiting a response");

endmodule

bind wr_conv_top wr_conv_asserts u_asserts (
  .ACLK      (ACLK),
  .ARESET    (ARESET),
  .s_awvalid (s_awvalid),
  .s_awready (s_awready),
  .m_awid    (m_awid),
  .m_awaddr  (m_awaddr),
  .m_awlen   (m_awlen),
  .m_awvalid (m_awvalid),
  .m_awready (m_awready),
  .m_wlast   (m_wlast),
  .m_wvalid  (m_wvalid),
  .m_wready  (m_wready),
  .s_bid     (s_bid),
  .s_bresp   (s_bresp),
  .s_bvalid  (s_bvalid),
  .s_bready  (s_bready)
);

// ==== wr_conv_tb.sv ====
`timescale 1ns/1ps

module wr_conv_tb import wr_conv_pkg::*; ();

  localparam int NUM_BURSTS = 40;
  localparam int TIMEOUT    = 2000;   // Cycles allowed for any single handshake.
  localparam int RUN_LIMIT  = 50000;

  logic ACLK;
  logic ARESET;
  logic [ID_W-1:0]      s_awid;
  logic [ADDR_W-1:0]    s_awaddr;
  logic [LEN_W-1:0]     s_awlen;
  logic                 s_awvalid, s_awready;
  logic [DATA_W-1:0]    s_wdata;
  logic [STRB_W-1:0]    s_wstrb;
  logic                 s_wlast, s_wvalid, s_wready;
  logic [ID_W-1:0]      s_bid;
  resp_t                s_bresp;
  logic                 s_bvalid, s_bready;
  logic [ID_W-1:0]      m_awid;
  logic [ADDR_W-1:0]    m_awaddr;
  logic [SUB_LEN_W-1:0] m_awlen;
  logic                 m_awvalid, m_awready;
  logic [DATA_W-1:0]    m_wdata;
  logic [STRB_W-1:0]    m_wstrb;
  logic                 m_wlast, m_wvalid, m_wready;
  logic [ID_W-1:0]      m_bid;
  resp_t                m_bresp;
  logic                 m_bvalid, m_bready;

  logic [31:0]       seed = 32'h91531d3e;
  logic [ID_W-1:0]   b_id   [NUM_BURSTS];
  logic [ADDR_W-1:0] b_addr [NUM_BURSTS];
  int                b_len  [NUM_BURSTS];
  int                b_nsub [NUM_BURSTS];

  // Reference queues, filled by the master and slave models.
  logic [ID_W-1:0]      exp_aw_id   [$];
  logic [ADDR_W-1:0]    exp_aw_addr [$];
  logic [SUB_LEN_W-1:0] exp_aw_len  [$];
  string                exp_aw_name [$];
  logic [DATA_W-1:0]    exp_w_data  [$];
  logic [STRB_W-1:0]    exp_w_strb  [$];
  logic                 exp_w_last  [$];
  string                exp_w_name  [$];
  logic [ID_W-1:0]      exp_b_id    [$];
  resp_t                exp_b_resp  [$];
  int                   exp_b_burst [$];
  logic [ID_W-1:0]      slave_aw_id [$];

  int   aw_seen     = 0;
  int   wlast_seen  = 0;
  int   bursts_done = 0;
  int   checks      = 0;
  int   errors      = 0;
  logic timed_out   = 1'b0;

  wr_conv_top i_dut (.*);

  initial begin
    ACLK = 1'b0;
    forever #20 ACLK = ~ACLK;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic flag_error(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic check_addr(input string name,
                            input logic [ID_W-1:0] exp_id, input logic [ID_W-1:0] act_id,
                            input logic [ADDR_W-1:0] exp_addr,
                            input logic [ADDR_W-1:0] act_addr,
                            input logic [SUB_LEN_W-1:0] exp_len,
                            input logic [SUB_LEN_W-1:0] act_len);
    checks++;
    if (exp_id !== act_id || exp_addr !== act_addr || exp_len !== act_len) begin
      $display("Fail %s: expected id %h addr %h len %h, actual id %h addr %h len %h",
               name, exp_id, exp_addr, exp_len, act_id, act_addr, act_len);
      errors++;
    end
  endtask

  task automatic check_data(input string name,
                            input logic [DATA_W-1:0] exp_data,
                            input logic [DATA_W-1:0] act_data,
                            input logic [STRB_W-1:0] exp_strb,
                            input logic [STRB_W-1:0] act_strb,
                            input logic exp_last, input logic act_last);
    checks++;
    if (exp_data !== act_data || exp_strb !== act_strb || exp_last !== act_last) begin
      $display("Fail %s: expected data %h strb %h last %b, actual data %h strb %h last %b",
               name, exp_data, exp_strb, exp_last, act_data, act_strb, act_last);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp_resp, input resp_t act_resp,
                            input logic [ID_W-1:0] exp_id, input logic [ID_W-1:0] act_id);
    checks++;
    if (exp_resp !== act_resp || exp_id !== act_id) begin
      $display("Fail %s: expected resp %h id %h, actual resp %h id %h",
               name, exp_resp, exp_id, act_resp, act_id);
      errors++;
    end
  endtask

  task automatic drive_aw();
    int n;
    int k;
    int cnt;
    int gap;
    for (n = 0; n < NUM_BURSTS; n++) begin
      s_awid    = b_id[n];
      s_awaddr  = b_addr[n];
      s_awlen   = LEN_W'(b_len[n]);
      s_awvalid = 1'b1;
      cnt = 0;
      do begin
        @(posedge ACLK);
        cnt++;
      end while (!s_awready && cnt < TIMEOUT);
      if (!s_awready) begin
        note_timeout("s_awready");
        return;
      end
      // Full sub-bursts of 16 beats, 64 bytes apart, then the remainder.
      for (k = 0; k < b_nsub[n]; k++) begin
        exp_aw_id.push_back(b_id[n]);
        exp_aw_addr.push_back(b_addr[n] + ADDR_W'(64 * k));
        exp_aw_len.push_back((k == b_nsub[n] - 1) ? SUB_LEN_W'(b_len[n] % 16) : SUB_LEN_W'(15));
        exp_aw_name.push_back($sformatf("burst %0d aw %0d", n, k));
      end
      #1;
      s_awvalid = 1'b0;
      gap = int'(next_rand() % 3);
      if (gap > 0) begin
        repeat (gap) @(posedge ACLK);
        #1;
      end
    end
  endtask

  task automatic drive_w();
    int n;
    int b;
    int cnt;
    logic [31:0] r;
    for (n = 0; n < NUM_BURSTS; n++) begin
      for (b = 0; b <= b_len[n]; b++) begin
        s_wdata = next_rand();
        r = next_rand();
        s_wstrb  = r[STRB_W-1:0];
        s_wlast  = (b == b_len[n]);
        s_wvalid = 1'b1;
        exp_w_data.push_back(s_wdata);
        exp_w_strb.push_back(s_wstrb);
        exp_w_last.push_back((b % 16 == 15) || (b == b_len[n]));
        exp_w_name.push_back($sformatf("burst %0d beat %0d", n, b));
        cnt = 0;
        do begin
          @(posedge ACLK);
          cnt++;
        end while (!s_wready && cnt < TIMEOUT);
        if (!s_wready) begin
          note_timeout("s_wready");
          return;
        end
        #1;
        s_wvalid = 1'b0;
        if (r[7:5] == 3'd0) begin  // Occasional idle cycle between beats.
          @(posedge ACLK);
          #1;
        end
      end
    end
  endtask

  task automatic respond_b();
    int n;
    int k;
    int cnt;
    int sent;
    logic [31:0] r;
    resp_t code;
    resp_t worst;
    sent = 0;
    for (n = 0; n < NUM_BURSTS; n++) begin
      for (k = 0; k < b_nsub[n]; k++) begin
        cnt = 0;
        // A response only follows both the address and the last data beat.
        while ((sent >= aw_seen || sent >= wlast_seen) && cnt < TIMEOUT) begin
          @(posedge ACLK);
          #1;
          cnt++;
        end
        if (sent >= aw_seen || sent >= wlast_seen) begin
          note_timeout("a completed sub-burst at the slave");
          return;
        end
        r = next_rand();
        code  = (r[3:0] < 4'd11) ? RESP_OKAY : resp_t'(r[5:4]);
        worst = (k == 0 || code > worst) ? code : worst;
        m_bid    = slave_aw_id.pop_front();
        m_bresp  = code;
        m_bvalid = 1'b1;
        if (k == b_nsub[n] - 1) begin
          exp_b_id.push_back(b_id[n]);
          exp_b_resp.push_back(worst);
          exp_b_burst.push_back(n);
        end
        cnt = 0;
        do begin
          @(posedge ACLK);
          cnt++;
        end while (!m_bready && cnt < TIMEOUT);
        if (!m_bready) begin
          note_timeout("m_bready");
          return;
        end
        #1;
        m_bvalid = 1'b0;
        sent++;
      end
    end
  endtask

  task automatic drive_ready();
    logic [31:0] r;
    forever begin
      @(posedge ACLK);
      #1;
      r = next_rand();
      m_awready = (r[1:0] != 2'b00);
      m_wready  = (r[3:2] != 2'b00);
      s_bready  = (r[5:4] != 2'b00);
    end
  endtask

  always @(posedge ACLK) begin
    if (!ARESET) begin
      if (m_awvalid && m_awready) begin
        if (exp_aw_id.size() == 0) begin
          flag_error("m_aw transfer with no sub-burst expected");
        end else begin
          check_addr(exp_aw_name.pop_front(), exp_aw_id.pop_front(), m_awid,
                     exp_aw_addr.pop_front(), m_awaddr, exp_aw_len.pop_front(), m_awlen);
        end
        slave_aw_id.push_back(m_awid);
        aw_seen++;
      end
      if (m_wvalid && m_wready) begin
        if (exp_w_data.size() == 0) begin
          flag_error("m_w beat with no data expected");
        end else begin
          check_data(exp_w_name.pop_front(), exp_w_data.pop_front(), m_wdata,
                     exp_w_strb.pop_front(), m_wstrb, exp_w_last.pop_front(), m_wlast);
        end
        if (m_wlast) wlast_seen++;
      end
      if (s_bvalid && s_bready) begin
        if (exp_b_id.size() == 0) begin
          flag_error("s_b response with no burst awaiting one");
        end else begin
          check_resp($sformatf("burst %0d resp", exp_b_burst[0]), exp_b_resp.pop_front(),
                     s_bresp, exp_b_id.pop_front(), s_bid);
          $display("burst %0d finished: %0d beats, %0d sub-bursts, errors so far %0d",
                   exp_b_burst[0], b_len[exp_b_burst[0]] + 1,
                   b_nsub[exp_b_burst[0]], errors);
          void'(exp_b_burst.pop_front());
        end
        bursts_done++;
      end
    end
  end

  initial begin
    int n;
    int cnt;
    logic [31:0] r;
    ARESET    = 1'b1;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wlast   = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bid     = '0;
    m_bresp   = RESP_OKAY;
    m_bvalid  = 1'b0;
    for (n = 0; n < NUM_BURSTS; n++) begin
      r = next_rand();
      b_id[n]  = r[ID_W-1:0];
      b_len[n] = (r[9:8] == 2'b00) ? int'(r[23:16]) : int'(r[19:16]);  // One in four is long.
      b_nsub[n] = b_len[n] / 16 + 1;
      r = next_rand();
      b_addr[n] = {r[ADDR_W-1:2], 2'b00};
    end
    repeat (4) @(posedge ACLK);
    #1;
    ARESET = 1'b0;
    fork
      drive_aw();
      drive_w();
      respond_b();
      drive_ready();
    join_none
    cnt = 0;
    while (bursts_done < NUM_BURSTS && !timed_out && cnt < RUN_LIMIT) begin
      @(posedge ACLK);
      cnt++;
    end
    if (cnt >= RUN_LIMIT) note_timeout("all bursts to complete");
    repeat (4) @(posedge ACLK);
    if (exp_aw_id.size() != 0) flag_error("expected sub-bursts never appeared on m_aw");
    if (exp_w_data.size() != 0) flag_error("expected beats never appeared on m_w");
    if (exp_b_id.size() != 0) flag_error("expected responses never appeared on s_b");
    $display("bursts %0d of %0d, checks %0d, errors %0d",
             bursts_done, NUM_BURSTS, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== wr_conv_top.f ====
wr_conv_pkg.sv
cmd_fifo.sv
aw_splitter.sv
w_last_gen.sv
b_merger.sv
wr_conv_top.sv
wr_conv_asserts.sv
wr_conv_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Compile and run the write converter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module wr_conv_tb -f wr_conv_top.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vwr_conv_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
exit 0
